// ==== list.f ====
+incdir+include
source/rt_pkg.sv
source/int_div.sv
source/int_math.sv
source/pipe_valid_stall.sv
source/sync_fifo.sv
source/int_unit.sv
verification/int_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= int_unit_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== include/int_model.svh ====
/*
  Intersection unit reference model.
  Exact integer copy of the transform, divide, barycentric and hit
  test math, and of the rule that routes each result to the list
  unit, the leaf arbiter, or both.
*/

`ifndef INT_MODEL_SVH
`define INT_MODEL_SVH

// math on one cacheline and ray, same fixed point as the datapath
function automatic void model_math(
  input  rt_pkg::int_cacheline_t cl,
  input  rt_pkg::ray_vec_t rv,
  output logic hit,
  output rt_pkg::float_t t,
  output rt_pkg::bari_uv_t uv
);
  longint ox, oy, oz, dx, dy, dz;
  longint num, q, u, v;
  ox = cl.m00 * rv.ox + cl.m01 * rv.oy + cl.m02 * rv.oz + (longint'(cl.tx) <<< 8);
  oy = cl.m10 * rv.ox + cl.m11 * rv.oy + cl.m12 * rv.oz + (longint'(cl.ty) <<< 8);
  oz = cl.m20 * rv.ox + cl.m21 * rv.oy + cl.m22 * rv.oz + (longint'(cl.tz) <<< 8);
  dx = cl.m00 * rv.dx + cl.m01 * rv.dy + cl.m02 * rv.dz;
  dy = cl.m10 * rv.dx + cl.m11 * rv.dy + cl.m12 * rv.dz;
  dz = cl.m20 * rv.dx + cl.m21 * rv.dy + cl.m22 * rv.dz;
  hit = 1'b0;
  t = '0;
  uv = '0;
  // ray parallel to the triangle plane
  if (dz == 0) begin
    return;
  end
  num = -(oz <<< 8);
  q = num / dz;
  if (q > 32767) begin
    q = 32767;
  end else if (q < -32768) begin
    q = -32768;
  end
  t = q[15:0];
  u = ox + ((longint'(t) * dx) >>> 8);
  v = oy + ((longint'(t) * dy) >>> 8);
  hit = (t > rt_pkg::EPSILON) && (u >= 0) && (v >= 0) && (u + v <= rt_pkg::ONE_Q16);
  if (hit) begin
    uv.u = (u == rt_pkg::ONE_Q16) ? 16'hffff : u[15:0];
    uv.v = (v == rt_pkg::ONE_Q16) ? 16'hffff : v[15:0];
  end
endfunction

// expected entries for one accepted input
function automatic void model_route(
  input  rt_pkg::icache_to_int_t item,
  output logic to_list,
  output rt_pkg::int_to_list_t list_e,
  output logic to_larb,
  output rt_pkg::leaf_info_t larb_e
);
  logic hit;
  rt_pkg::float_t t;
  rt_pkg::bari_uv_t uv;
  rt_pkg::ln_tri_t ln;
  model_math(item.tri_cacheline, item.ray_vec, hit, t, uv);
  ln.lindex = item.ln_tri.lindex + 1'b1;
  ln.lnum_left = item.ln_tri.lnum_left - 1'b1;
  list_e.rayID = item.rayID;
  list_e.triID = item.triID;
  list_e.hit = hit;
  list_e.t_int = t;
  list_e.uv = uv;
  larb_e.rayID = item.rayID;
  larb_e.ln_tri = ln;
  to_list = hit || (ln.lnum_left == 0);
  to_larb = (ln.lnum_left != 0);
endfunction

`endif

// ==== verification/int_unit_tb.sv ====
/*
  Intersection unit testbench.
  Random triangles and rays from a fixed seed, random and held output
  stalls, and a scoreboard that checks both output ports in order
  against the reference model.
*/

`timescale 1ns/1ps

module int_unit_tb;
  import rt_pkg::*;

  `include "int_model.svh"

  localparam int N_FREE = 200;
  localparam int N_ZERO = 12;
  localparam int N_RAND = 300;
  localparam int N_HOLD = 150;
  localparam int HOLD_CYCLES = 300;
  localparam int DRAIN_LIMIT = 1500;
  localparam int TOTAL_ITEMS = N_FREE + N_ZERO + N_RAND + N_HOLD;
  localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * 4 + INT_LATENCY + 200;

  logic clk;
  logic arst_n;
  logic icache_to_int_valid;
  icache_to_int_t icache_to_int_data;
  logic icache_to_int_stall;
  logic int_to_list_valid;
  int_to_list_t int_to_list_data;
  logic int_to_list_stall;
  logic int_to_larb_valid;
  leaf_info_t int_to_larb_data;
  logic int_to_larb_stall;

  integer seed = 32'hac16;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int test_err_start;
  int items_in, hits_in, list_out, larb_out;

  // 0 never stall, 1 random, 2 held
  int list_mode = 0;
  int larb_mode = 0;
  bit stall_rose, stall_released;
  int larb_in_hold;

  int_to_list_t list_q[$];
  leaf_info_t larb_q[$];

  int_unit uut (
    .clk,
    .arst_n,
    .icache_to_int_valid,
    .icache_to_int_data,
    .icache_to_int_stall,
    .int_to_list_valid,
    .int_to_list_data,
    .int_to_list_stall,
    .int_to_larb_valid,
    .int_to_larb_data,
    .int_to_larb_stall
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog timed out after %0d cycles, outputs stopped arriving",
             WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  function automatic int rand_range(input int lo, input int span);
    int r;
    r = {$random(seed)} % span;
    return lo + r;
  endfunction

  function automatic logic stall_for(input int mode);
    if (mode == 2) begin
      return 1'b1;
    end
    if (mode == 1) begin
      return rand_range(0, 3) == 0;
    end
    return 1'b0;
  endfunction

  // near-identity matrix, origin above the unit triangle, so roughly half hit
  function automatic icache_to_int_t make_item(input bit zero_dz);
    icache_to_int_t it;
    it.rayID = rayID_t'($random(seed));
    it.triID = triID_t'($random(seed));
    it.ln_tri.lindex = 8'(rand_range(0, 256));
    it.ln_tri.lnum_left = zero_dz ? 8'd1 : 8'(rand_range(1, 4));
    it.tri_cacheline.m00 = coord_t'(rand_range(248, 17));
    it.tri_cacheline.m01 = coord_t'(rand_range(-4, 9));
    it.tri_cacheline.m02 = coord_t'(rand_range(-4, 9));
    it.tri_cacheline.m10 = coord_t'(rand_range(-4, 9));
    it.tri_cacheline.m11 = coord_t'(rand_range(248, 17));
    it.tri_cacheline.m12 = coord_t'(rand_range(-4, 9));
    it.tri_cacheline.m20 = zero_dz ? coord_t'(0) : coord_t'(rand_range(-4, 9));
    it.tri_cacheline.m21 = zero_dz ? coord_t'(0) : coord_t'(rand_range(-4, 9));
    it.tri_cacheline.m22 = coord_t'(rand_range(248, 17));
    it.tri_cacheline.tx = coord_t'(rand_range(-32, 64));
    it.tri_cacheline.ty = coord_t'(rand_range(-32, 64));
    it.tri_cacheline.tz = '0;
    it.ray_vec.ox = coord_t'(rand_range(0, 154));
    it.ray_vec.oy = coord_t'(rand_range(0, 154));
    it.ray_vec.oz = coord_t'(-rand_range(256, 512));
    it.ray_vec.dx = coord_t'(rand_range(-12, 25));
    it.ray_vec.dy = coord_t'(rand_range(-12, 25));
    it.ray_vec.dz = coord_t'(rand_range(128, 256));
    // a few rays point away from the triangle
    if (rand_range(0, 8) == 0) begin
      it.ray_vec.dz = -it.ray_vec.dz;
    end
    if (zero_dz) begin
      it.ray_vec.dz = '0;
    end
    return it;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic record_input(input icache_to_int_t item);
    logic to_list;
    logic to_larb;
    int_to_list_t list_e;
    leaf_info_t larb_e;
    model_route(item, to_list, list_e, to_larb, larb_e);
    items_in++;
    if (list_e.hit) begin
      hits_in++;
    end
    if (to_list) begin
      list_q.push_back(list_e);
    end
    if (to_larb) begin
      larb_q.push_back(larb_e);
    end
  endtask

  task automatic check_list(input int_to_list_t got);
    int_to_list_t exp;
    list_out++;
    if (list_q.size() == 0) begin
      errors++;
      $display("list port produced an output with nothing pending");
      return;
    end
    exp = list_q.pop_front();
    check_val("int_to_list_data.rayID", got.rayID, exp.rayID);
    check_val("int_to_list_data.triID", got.triID, exp.triID);
    check_val("int_to_list_data.hit", got.hit, exp.hit);
    check_val("int_to_list_data.t_int", got.t_int, exp.t_int);
    check_val("int_to_list_data.uv", got.uv, exp.uv);
  endtask

  task automatic check_larb(input leaf_info_t got);
    leaf_info_t exp;
    larb_out++;
    if (larb_q.size() == 0) begin
      errors++;
      $display("larb port produced an output with nothing pending");
      return;
    end
    exp = larb_q.pop_front();
    check_val("int_to_larb_data.rayID", got.rayID, exp.rayID);
    check_val("int_to_larb_data.lindex", got.ln_tri.lindex, exp.ln_tri.lindex);
    check_val("int_to_larb_data.lnum_left", got.ln_tri.lnum_left, exp.ln_tri.lnum_left);
  endtask

  // sampled mid-cycle, a transfer here completes on the next rising edge
  always @(negedge clk) begin
    if (arst_n) begin
      if (icache_to_int_valid && !icache_to_int_stall) begin
        record_input(icache_to_int_data);
      end
      if (int_to_list_valid && !int_to_list_stall) begin
        check_list(int_to_list_data);
      end
      if (int_to_larb_valid && !int_to_larb_stall) begin
        check_larb(int_to_larb_data);
        if (list_mode == 2) begin
          larb_in_hold++;
        end
      end
      if (icache_to_int_stall) begin
        stall_rose = 1'b1;
      end else if (stall_rose) begin
        stall_released = 1'b1;
      end
    end
  end

  initial begin
    int_to_list_stall = 1'b0;
    int_to_larb_stall = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      int_to_list_stall = stall_for(list_mode);
      int_to_larb_stall = stall_for(larb_mode);
    end
  end

  task automatic align_drive();
    @(posedge clk);
    #1;
  endtask

  // hold the item until the unit takes it
  task automatic feed_item(input icache_to_int_t item);
    icache_to_int_valid = 1'b1;
    icache_to_int_data = item;
    @(negedge clk);
    while (icache_to_int_stall) begin
      @(negedge clk);
    end
    align_drive();
  endtask

  task automatic stop_input();
    icache_to_int_valid = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((list_q.size() != 0 || larb_q.size() != 0) && n < DRAIN_LIMIT) begin
      @(posedge clk);
      n++;
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic start_test();
    test_err_start = errors;
    items_in = 0;
    hits_in = 0;
    list_out = 0;
    larb_out = 0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("test %s: %0d items, %0d hits, %0d list, %0d larb, %0d errors",
             name, items_in, hits_in, list_out, larb_out, errors - test_err_start);
  endtask

  initial begin
    arst_n = 1'b0;
    icache_to_int_valid = 1'b0;
    icache_to_int_data = '0;
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;

    start_test();
    repeat (10) begin
      @(negedge clk);
      check_val("int_to_list_valid", int_to_list_valid, 0);
      check_val("int_to_larb_valid", int_to_larb_valid, 0);
      check_val("icache_to_int_stall", icache_to_int_stall, 0);
    end
    end_test("idle_after_reset");

    start_test();
    align_drive();
    repeat (N_FREE) feed_item(make_item(1'b0));
    stop_input();
    drain();
    end_test("no_stall_routing");

    start_test();
    @(negedge clk);
    align_drive();
    repeat (N_ZERO) feed_item(make_item(1'b1));
    stop_input();
    drain();
    end_test("zero_direction_z");

    start_test();
    @(negedge clk);
    list_mode = 1;
    larb_mode = 1;
    align_drive();
    repeat (N_RAND) feed_item(make_item(1'b0));
    stop_input();
    drain();
    end_test("random_stalls");

    start_test();
    @(negedge clk);
    list_mode = 2;
    larb_mode = 0;
    stall_rose = 1'b0;
    stall_released = 1'b0;
    larb_in_hold = 0;
    align_drive();
    fork
      begin
        repeat (N_HOLD) feed_item(make_item(1'b0));
        stop_input();
      end
      begin
        repeat (HOLD_CYCLES) @(negedge clk);
        list_mode = 1;
        larb_mode = 1;
      end
    join
    drain();
    if (!stall_rose) begin
      errors++;
      $display("upstream stall never rose while the list port was held");
    end
    if (!stall_released) begin
      errors++;
      $display("upstream stall never released after the list port resumed");
    end
    if (larb_in_hold == 0) begin
      errors++;
      $display("larb port stopped draining while the list port was held");
    end
    end_test("list_port_held");

    if (list_q.size() != 0) begin
      errors++;
      $display("missing outputs: %0d list entries never appeared", list_q.size());
    end
    if (larb_q.size() != 0) begin
      errors++;
      $display("missing outputs: %0d larb entries never appeared", larb_q.size());
    end

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== source/int_unit.sv ====
/*
  Triangle intersection unit.
  Accepts one triangle cacheline and ray per cycle, updates the leaf
  list state, and routes results to the list unit and the leaf arbiter
  through two output FIFOs. Upstream stalls before either FIFO fills.
*/

`timescale 1ns/1ps

module int_unit (
  input  logic clk,
  input  logic arst_n,

  input  logic icache_to_int_valid,
  input  rt_pkg::icache_to_int_t icache_to_int_data,
  output logic icache_to_int_stall,

  output logic int_to_list_valid,
  output rt_pkg::int_to_list_t int_to_list_data,
  input  logic int_to_list_stall,

  output logic int_to_larb_valid,
  output rt_pkg::leaf_info_t int_to_larb_data,
  input  logic int_to_larb_stall
);
  import rt_pkg::*;

  logic hit;
  float_t t_int;
  bari_uv_t uv;

  int_side_t side_in, side_out;
  logic side_valid;

  int_to_list_t list_wr_data;
  leaf_info_t larb_wr_data;
  logic list_wr, larb_wr;
  logic list_rd, larb_rd;
  logic list_empty, larb_empty;
  logic [FIFO_CNT_W-1:0] list_count, larb_count, max_count;

  int_math math_inst (
    .clk,
    .arst_n,
    .int_cacheline(icache_to_int_data.tri_cacheline),
    .ray_vec(icache_to_int_data.ray_vec),
    .hit,
    .t_int,
    .uv
  );

  // this triangle is consumed, move to the next list entry
  always_comb begin
    side_in.rayID = icache_to_int_data.rayID;
    side_in.triID = icache_to_int_data.triID;
    side_in.ln_tri.lnum_left = icache_to_int_data.ln_tri.lnum_left - 1'b1;
    side_in.ln_tri.lindex = icache_to_int_data.ln_tri.lindex + 1'b1;
  end

  assign max_count = (list_count > larb_count) ? list_count : larb_count;

  pipe_valid_stall pipe_inst (
    .clk,
    .arst_n,
    .us_valid(icache_to_int_valid),
    .us_data(side_in),
    .us_stall(icache_to_int_stall),
    .ds_valid(side_valid),
    .ds_data(side_out),
    .num_in_fifo(max_count)
  );

  always_comb begin
    list_wr_data.rayID = side_out.rayID;
    list_wr_data.triID = side_out.triID;
    list_wr_data.hit = hit;
    list_wr_data.t_int = t_int;
    list_wr_data.uv = uv;
    larb_wr_data.rayID = side_out.rayID;
    larb_wr_data.ln_tri = side_out.ln_tri;
  end

  // last triangle of a leaf always reports, hits always report
  assign list_wr = side_valid & (hit | (side_out.ln_tri.lnum_left == '0));
  // leaf not done yet, hand the list state back to the arbiter
  assign larb_wr = side_valid & (side_out.ln_tri.lnum_left != '0);

  sync_fifo #(.payload_t(int_to_list_t)) list_fifo (
    .clk,
    .arst_n,
    .wr_en(list_wr),
    .wr_data(list_wr_data),
    .rd_en(list_rd),
    .rd_data(int_to_list_data),
    .empty(list_empty),
    .count(list_count)
  );

  sync_fifo #(.payload_t(leaf_info_t)) larb_fifo (
    .clk,
    .arst_n,
    .wr_en(larb_wr),
    .wr_data(larb_wr_data),
    .rd_en(larb_rd),
    .rd_data(int_to_larb_data),
    .empty(larb_empty),
    .count(larb_count)
  );

  assign int_to_list_valid = ~list_empty;
  assign list_rd = int_to_list_valid & ~int_to_list_stall;

  assign int_to_larb_valid = ~larb_empty;
  assign larb_rd = int_to_larb_valid & ~int_to_larb_stall;

endmodule

// ==== source/sync_fifo.sv ====
/*
  Synchronous first-word-fall-through FIFO.
  Circular buffer of FIFO_DEPTH words of any packed payload. The head
  word is visible whenever the FIFO is not empty, and the occupancy
  is reported every cycle.
*/

`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  logic clk,
  input  logic arst_n,
  input  logic wr_en,
  input  payload_t wr_data,
  input  logic rd_en,
  output payload_t rd_data,
  output logic empty,
  output logic [rt_pkg::FIFO_CNT_W-1:0] count
);
  import rt_pkg::*;

  payload_t mem [FIFO_DEPTH];
  // pointers wrap on their own at the depth
  logic [FIFO_CNT_W-2:0] wr_ptr, rd_ptr;
  logic do_rd;

  assign do_rd = rd_en & ~empty;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + wr_en - do_rd;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  assign rd_data = mem[rd_ptr];
  assign empty = (count == '0);

endmodule

// ==== source/pipe_valid_stall.sv ====
/*
  Valid and sideband delay line.
  Keeps ray and leaf state in step with the math pipe, counts the
  items in flight and stalls upstream before the output FIFOs could
  run out of room.
*/

`timescale 1ns/1ps

module pipe_valid_stall (
  input  logic clk,
  input  logic arst_n,
  input  logic us_valid,
  input  rt_pkg::int_side_t us_data,
  output logic us_stall,
  output logic ds_valid,
  output rt_pkg::int_side_t ds_data,
  input  logic [rt_pkg::FIFO_CNT_W-1:0] num_in_fifo
);
  import rt_pkg::*;

  logic [INT_LATENCY-1:0] valid_q;
  int_side_t data_q [INT_LATENCY];
  logic [FIFO_CNT_W-1:0] inflight_q;
  logic [FIFO_CNT_W:0] occupancy;
  logic accept;

  // everything in flight may still land in the fuller FIFO
  assign occupancy = inflight_q + num_in_fifo;
  assign us_stall = occupancy >= FIFO_DEPTH - 1;
  assign accept = us_valid & ~us_stall;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
      inflight_q <= '0;
    end else begin
      valid_q <= {valid_q[INT_LATENCY-2:0], accept};
      inflight_q <= inflight_q + accept - valid_q[INT_LATENCY-1];
    end
  end

  always_ff @(posedge clk) begin
    data_q[0] <= us_data;
    for (int k = 1; k < INT_LATENCY; k++) begin
      data_q[k] <= data_q[k-1];
    end
  end

  assign ds_valid = valid_q[INT_LATENCY-1];
  assign ds_data = data_q[INT_LATENCY-1];

endmodule

// ==== source/int_math.sv ====
/*
  Triangle intersection datapath.
  Maps the ray into unit-triangle space, divides for the hit distance,
  forms the barycentric coordinates and runs the hit test. Fixed
  latency of INT_LATENCY cycles, one new operation per cycle.
*/

`timescale 1ns/1ps

module int_math (
  input  logic clk,
  input  logic arst_n,
  input  rt_pkg::int_cacheline_t int_cacheline,
  input  rt_pkg::ray_vec_t ray_vec,
  output logic hit,
  output rt_pkg::float_t t_int,
  output rt_pkg::bari_uv_t uv
);
  import rt_pkg::*;

  // stage 1, transformed origin and direction
  wide_t ox_q, oy_q, oz_q;
  wide_t dx_q, dy_q, dz_q;

  // stage 2, divider operands
  logic signed [DIV_W-1:0] num_q;
  wide_t den_q;

  // x and y components waiting for the quotient
  logic [4*WIDE_W-1:0] xy_dly [DIV_W+1];
  wide_t ox_d, oy_d, dx_d, dy_d;

  float_t t_div;
  logic div_zero;

  // t times direction is Q24.24, 56 bits covers it
  logic signed [55:0] prod_x, prod_y;
  logic signed [55:0] u_d, v_d;
  logic signed [55:0] u_q, v_q;
  float_t t_q;
  logic zero_q;

  logic hit_d;
  bari_uv_t uv_d;

  function automatic wide_t dot3(
    input coord_t a0, a1, a2,
    input coord_t b0, b1, b2
  );
    wide_t p0, p1, p2;
    p0 = a0 * b0;
    p1 = a1 * b1;
    p2 = a2 * b2;
    return p0 + p1 + p2;
  endfunction

  always_ff @(posedge clk) begin
    ox_q <= dot3(int_cacheline.m00, int_cacheline.m01, int_cacheline.m02,
                 ray_vec.ox, ray_vec.oy, ray_vec.oz) + (wide_t'(int_cacheline.tx) <<< 8);
    oy_q <= dot3(int_cacheline.m10, int_cacheline.m11, int_cacheline.m12,
                 ray_vec.ox, ray_vec.oy, ray_vec.oz) + (wide_t'(int_cacheline.ty) <<< 8);
    oz_q <= dot3(int_cacheline.m20, int_cacheline.m21, int_cacheline.m22,
                 ray_vec.ox, ray_vec.oy, ray_vec.oz) + (wide_t'(int_cacheline.tz) <<< 8);
    dx_q <= dot3(int_cacheline.m00, int_cacheline.m01, int_cacheline.m02,
                 ray_vec.dx, ray_vec.dy, ray_vec.dz);
    dy_q <= dot3(int_cacheline.m10, int_cacheline.m11, int_cacheline.m12,
                 ray_vec.dx, ray_vec.dy, ray_vec.dz);
    dz_q <= dot3(int_cacheline.m20, int_cacheline.m21, int_cacheline.m22,
                 ray_vec.dx, ray_vec.dy, ray_vec.dz);

    // oz is widened before the shift, so nothing drops off the top
    num_q <= -(oz_q <<< 8);
    den_q <= dz_q;

    xy_dly[0] <= {ox_q, oy_q, dx_q, dy_q};
    for (int k = 1; k <= DIV_W; k++) begin
      xy_dly[k] <= xy_dly[k-1];
    end
  end

  int_div div_inst (
    .clk,
    .arst_n,
    .num(num_q),
    .den(den_q),
    .quo(t_div),
    .zero_den(div_zero)
  );

  assign {ox_d, oy_d, dx_d, dy_d} = xy_dly[DIV_W];

  always_comb begin
    prod_x = t_div * dx_d;
    prod_y = t_div * dy_d;
    u_d = ox_d + (prod_x >>> 8);
    v_d = oy_d + (prod_y >>> 8);
  end

  always_ff @(posedge clk) begin
    u_q <= u_d;
    v_q <= v_d;
    t_q <= t_div;
    zero_q <= div_zero;
  end

  always_comb begin
    hit_d = !zero_q && (t_q > EPSILON) && (u_q >= 0) && (v_q >= 0) &&
            (u_q + v_q <= ONE_Q16);
    uv_d.u = (u_q == ONE_Q16) ? 16'hffff : u_q[15:0];
    uv_d.v = (v_q == ONE_Q16) ? 16'hffff : v_q[15:0];
    if (!hit_d) begin
      uv_d = '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hit <= 1'b0;
    end else begin
      hit <= hit_d;
    end
  end

  always_ff @(posedge clk) begin
    t_int <= t_q;
    uv <= uv_d;
  end

endmodule

// ==== source/int_div.sv ====
/*
  Pipelined signed divider.
  Restoring division on magnitudes, one quotient bit per stage, with
  the sign and the zero-divisor flag carried alongside. The quotient
  is truncated toward zero and saturated to 16 signed bits.
*/

`timescale 1ns/1ps

module int_div (
  input  logic clk,
  input  logic arst_n,
  input  logic signed [rt_pkg::DIV_W-1:0] num,
  input  rt_pkg::wide_t den,
  output rt_pkg::float_t quo,
  output logic zero_den
);
  import rt_pkg::*;

  logic [DIV_W-1:0] num_mag;
  logic [WIDE_W-1:0] den_mag;

  // acc holds the unused dividend bits on top, quotient bits below
  logic [DIV_W-1:0] acc_q [DIV_W];
  logic [DIV_W-1:0] acc_d [DIV_W];
  logic [WIDE_W-1:0] rem_q [DIV_W];
  logic [WIDE_W-1:0] rem_d [DIV_W];
  logic [WIDE_W-1:0] dmag_q [DIV_W];
  logic [DIV_W-1:0] neg_q, zero_q;
  logic [DIV_W-1:0] q_mag;

  function automatic void div_step(
    input  logic [WIDE_W-1:0] rem,
    input  logic [DIV_W-1:0] acc,
    input  logic [WIDE_W-1:0] dmag,
    output logic [WIDE_W-1:0] rem_o,
    output logic [DIV_W-1:0] acc_o
  );
    logic [WIDE_W:0] trial;
    logic [WIDE_W:0] diff;
    trial = {rem, acc[DIV_W-1]};
    diff = trial - {1'b0, dmag};
    if (trial >= {1'b0, dmag}) begin
      rem_o = diff[WIDE_W-1:0];
      acc_o = {acc[DIV_W-2:0], 1'b1};
    end else begin
      rem_o = trial[WIDE_W-1:0];
      acc_o = {acc[DIV_W-2:0], 1'b0};
    end
  endfunction

  assign num_mag = num[DIV_W-1] ? -num : num;
  assign den_mag = den[WIDE_W-1] ? -den : den;

  always_comb begin
    div_step('0, num_mag, den_mag, rem_d[0], acc_d[0]);
    for (int k = 1; k < DIV_W; k++) begin
      div_step(rem_q[k-1], acc_q[k-1], dmag_q[k-1], rem_d[k], acc_d[k]);
    end
  end

  always_ff @(posedge clk) begin
    dmag_q[0] <= den_mag;
    for (int k = 0; k < DIV_W; k++) begin
      rem_q[k] <= rem_d[k];
      acc_q[k] <= acc_d[k];
    end
    for (int k = 1; k < DIV_W; k++) begin
      dmag_q[k] <= dmag_q[k-1];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      neg_q  <= '0;
      zero_q <= '0;
    end else begin
      neg_q  <= {neg_q[DIV_W-2:0], num[DIV_W-1] ^ den[WIDE_W-1]};
      zero_q <= {zero_q[DIV_W-2:0], den == '0};
    end
  end

  assign q_mag = acc_q[DIV_W-1];
  assign zero_den = zero_q[DIV_W-1];

  // sign fixup and saturation on the last stage
  always_comb begin
    if (zero_den) begin
      quo = '0;
    end else if (!neg_q[DIV_W-1]) begin
      quo = (q_mag > 32767) ? 16'sh7fff : q_mag[15:0];
    end else begin
      quo = (q_mag > 32768) ? 16'sh8000 : ~q_mag[15:0] + 1'b1;
    end
  end

endmodule

// ==== source/rt_pkg.sv ====
/*
  Ray tracer intersection types and constants.
  Fixed-point coordinate and result types, the payloads that travel
  between the instruction cache, the intersection unit, the list unit
  and the leaf arbiter, and the pipeline depth constants.
*/

package rt_pkg;

  // divider stages, one quotient bit each
  localparam int DIV_W = 48;
  localparam int INT_LATENCY = DIV_W + 4;
  localparam int FIFO_DEPTH = 64;
  localparam int FIFO_CNT_W = 7;
  localparam int WIDE_W = 40;

  // Q8.8 coordinate
  typedef logic signed [15:0] coord_t;
  // Q16.16 transformed value
  typedef logic signed [WIDE_W-1:0] wide_t;
  // hit distance, Q8.8
  typedef logic signed [15:0] float_t;

  typedef logic [7:0] rayID_t;
  typedef logic [11:0] triID_t;

  typedef struct packed {
    coord_t m00, m01, m02;
    coord_t m10, m11, m12;
    coord_t m20, m21, m22;
    coord_t tx, ty, tz;
  } int_cacheline_t;

  typedef struct packed {
    coord_t ox, oy, oz;
    coord_t dx, dy, dz;
  } ray_vec_t;

  // lnum_left counts this triangle too
  typedef struct packed {
    logic [7:0] lindex;
    logic [7:0] lnum_left;
  } ln_tri_t;

  // unsigned Q0.16 barycentrics
  typedef struct packed {
    logic [15:0] u;
    logic [15:0] v;
  } bari_uv_t;

  typedef struct packed {
    rayID_t rayID;
    triID_t triID;
    ln_tri_t ln_tri;
    int_cacheline_t tri_cacheline;
    ray_vec_t ray_vec;
  } icache_to_int_t;

  typedef struct packed {
    rayID_t rayID;
    triID_t triID;
    logic hit;
    float_t t_int;
    bari_uv_t uv;
  } int_to_list_t;

  typedef struct packed {
    rayID_t rayID;
    ln_tri_t ln_tri;
  } leaf_info_t;

  typedef struct packed {
    rayID_t rayID;
    triID_t triID;
    ln_tri_t ln_tri;
  } int_side_t;

  localparam float_t EPSILON = 16'sd1;
  localparam int ONE_Q16 = 65536;

endpackage
